//--- common/core_pkg.sv
package core_pkg;

  localparam int xlen = 32;

  typedef struct packed {
    logic rden1;
    logic rden2;
    logic wren;
    logic load;
    logic store;
    logic crden;
    logic cwren;
    logic fpunit;
    logic fpuf;    // Sets fflags.
    logic illegal;
  } operation_type;

  localparam operation_type init_operation = '0;

  typedef struct packed {
    logic valid;
    operation_type op;
    logic [4:0] raddr1;
    logic [4:0] raddr2;
    logic [4:0] waddr;
    logic [11:0] caddr;
    logic [2:0] rm;
    logic [xlen-1:0] rdata1;
    logic [xlen-1:0] rdata2;
    logic [xlen-1:0] cdata;
  } calculation_type;

  localparam calculation_type init_calculation = '0;

  // Data fields are left empty by decode.
  typedef struct packed {
    calculation_type slot0;
    calculation_type slot1;
  } decode_pair_type;

  typedef struct packed {
    logic load;
    logic [4:0] waddr;
    logic cwren;
    logic fpuf;
  } execute_slot_type;

  typedef struct packed {
    execute_slot_type ex0;
    execute_slot_type ex1;
    logic mem_cwren;   // Still in memory stage.
    logic mem_fpuf;
  } execute_state_type;

  typedef struct packed {
    logic wren;
    logic [4:0] waddr;
    logic [xlen-1:0] wdata;
  } writeback_slot_type;

  typedef struct packed {
    writeback_slot_type slot0;
    writeback_slot_type slot1;
  } writeback_type;

endpackage

//--- common/csr_pkg.sv
package csr_pkg;

  localparam logic [11:0] csr_fflags = 12'h001;
  localparam logic [11:0] csr_frm = 12'h002;
  localparam logic [11:0] csr_fcsr = 12'h003;
  localparam logic [11:0] csr_mstatus = 12'h300;

  typedef struct packed {
    logic [23:0] reserved;
    logic [2:0] frm;
    logic [4:0] fflags;
  } fcsr_fields_type;

  // Same word, seen raw or by field.
  typedef union packed {
    logic [31:0] raw;
    fcsr_fields_type fields;
  } fcsr_type;

  typedef struct packed {
    logic crden;
    logic [11:0] craddr;
  } csr_read_type;

  typedef struct packed {
    logic cwren;
    logic [11:0] cwaddr;
    logic [core_pkg::xlen-1:0] cwdata;
  } csr_write_type;

endpackage

//--- issue/pair_hazard.sv
`timescale 1ns/1ps

module pair_hazard import core_pkg::*; (
  input logic clock,
  input logic reset,
  input decode_pair_type pair,
  input logic clear,
  input logic hold,
  input logic stall,
  output calculation_type cand0,
  output calculation_type cand1,
  output logic split
);

  calculation_type deferred;
  logic pending;
  logic dep;
  logic mem_pair;
  logic csr_any;
  logic split_pair;

  always_comb begin
    dep = pair.slot0.valid & pair.slot0.op.wren &
          ((pair.slot1.op.rden1 & (pair.slot1.raddr1 == pair.slot0.waddr)) |
           (pair.slot1.op.rden2 & (pair.slot1.raddr2 == pair.slot0.waddr)));
    mem_pair = pair.slot0.valid & (pair.slot0.op.load | pair.slot0.op.store) &
               (pair.slot1.op.load | pair.slot1.op.store);
    csr_any = pair.slot1.op.crden | pair.slot1.op.cwren |
              (pair.slot0.valid & (pair.slot0.op.crden | pair.slot0.op.cwren));
    split_pair = pair.slot1.valid & (dep | mem_pair | csr_any);

    if (pending) begin
      cand0 = deferred; // Deferred slot goes out alone.
      cand1 = init_calculation;
      split = 1'b0;
    end else begin
      cand0 = pair.slot0;
      cand1 = split_pair ? init_calculation : pair.slot1;
      split = split_pair;
    end
  end

  always_ff @(posedge clock) begin
    if (!reset) begin
      pending <= 1'b0;
    end else if (hold || (stall && !clear)) begin
      pending <= pending;
    end else if (clear) begin
      pending <= 1'b0;
    end else begin
      pending <= !pending && split_pair;
    end
  end

  always_ff @(posedge clock) begin
    if (!pending && split_pair && !hold && !stall) begin
      deferred <= pair.slot1;
    end
  end

  // The deferred slot leaves on the first free cycle.
  assert property (@(posedge clock) disable iff (!reset)
    pending && !hold && !stall |=> !pending);

endmodule

//--- issue/issue_stage.sv
`timescale 1ns/1ps

module issue_stage import core_pkg::*; import csr_pkg::*; (
  input logic clock,
  input logic reset,
  input calculation_type cand0,
  input calculation_type cand1,
  input logic split,
  input logic clear,
  input logic hold,
  input execute_state_type ex_state,
  output logic [3:0][4:0] raddr,
  output logic [3:0] ren,
  input logic [3:0][xlen-1:0] rdata,
  output csr_read_type csr_rd,
  input logic [xlen-1:0] cdata,
  input logic [1:0] fs,
  input logic [2:0] frm,
  output calculation_type issue0,
  output calculation_type issue1,
  output logic stall,
  output logic halt
);

  calculation_type g0;
  calculation_type g1;
  calculation_type n0;
  calculation_type n1;
  logic fp_pending;
  logic cw_pending;
  logic stall_cond;

  function automatic calculation_type fp_resolve(calculation_type c, logic [1:0] fs_v,
                                                 logic [2:0] frm_v);
    calculation_type r;
    r = c;
    if (fs_v == 2'b00) begin
      r.op.illegal = c.op.illegal | c.op.fpunit | c.op.fpuf; // FP unit is off.
      r.op.fpunit = 1'b0;
      r.op.fpuf = 1'b0;
      r.rm = 3'b000;
    end
    if (r.rm == 3'b111) begin
      r.rm = frm_v; // Dynamic rounding.
    end
    return r;
  endfunction

  function automatic logic load_use(calculation_type c, execute_slot_type e);
    return c.valid & e.load &
           ((c.op.rden1 & (c.raddr1 == e.waddr)) | (c.op.rden2 & (c.raddr2 == e.waddr)));
  endfunction

  function automatic logic reads_fflags(calculation_type c);
    return c.valid & c.op.crden & ((c.caddr == csr_fflags) | (c.caddr == csr_fcsr));
  endfunction

  always_comb begin
    g0 = fp_resolve(cand0, fs, frm);
    g1 = fp_resolve(cand1, fs, frm);

    raddr = {g1.raddr2, g1.raddr1, g0.raddr2, g0.raddr1};
    ren = {g1.valid & g1.op.rden2, g1.valid & g1.op.rden1,
           g0.valid & g0.op.rden2, g0.valid & g0.op.rden1};

    // Never two CSR accesses in one pair.
    csr_rd.crden = (g0.valid & g0.op.crden) | (g1.valid & g1.op.crden);
    csr_rd.craddr = (g0.valid & g0.op.crden) ? g0.caddr : g1.caddr;

    g0.rdata1 = rdata[0];
    g0.rdata2 = rdata[1];
    g1.rdata1 = rdata[2];
    g1.rdata2 = rdata[3];
    g0.cdata = cdata;
    g1.cdata = cdata;

    fp_pending = ex_state.ex0.fpuf | ex_state.ex1.fpuf | ex_state.mem_fpuf;
    cw_pending = ex_state.ex0.cwren | ex_state.ex1.cwren | ex_state.mem_cwren;

    stall_cond = cw_pending |
                 (fp_pending & (reads_fflags(g0) | reads_fflags(g1))) |
                 load_use(g0, ex_state.ex0) | load_use(g0, ex_state.ex1) |
                 load_use(g1, ex_state.ex0) | load_use(g1, ex_state.ex1);

    n0 = g0;
    n1 = g1;
    if (stall_cond) begin
      n0.valid = 1'b0;
      n0.op = init_operation;
      n1.valid = 1'b0;
      n1.op = init_operation;
    end
    if (clear) begin
      n0 = init_calculation;
      n1 = init_calculation;
    end

    stall = stall_cond & ~clear;
    halt = split & ~clear;
  end

  always_ff @(posedge clock) begin
    if (!reset) begin
      issue0 <= init_calculation;
      issue1 <= init_calculation;
    end else if (!hold) begin
      issue0 <= n0;
      issue1 <= n1;
    end
  end

  // CSR accesses are split off by the pairing logic.
  assert property (@(posedge clock) disable iff (!reset)
    issue1.valid |-> !(issue1.op.crden || issue1.op.cwren));

  assert property (@(posedge clock) disable iff (!reset)
    clear && !hold |-> !stall ##1 !(issue0.valid || issue1.valid));

endmodule

//--- logic/int_regfile.sv
`timescale 1ns/1ps

module int_regfile import core_pkg::*; #(
  parameter int depth = 32
) (
  input logic clock,
  input logic [3:0][4:0] raddr,
  input logic [3:0] ren,
  output logic [3:0][xlen-1:0] rdata,
  input writeback_type wb
);

  logic [xlen-1:0] regs [depth];

  always_comb begin
    for (int i = 0; i < 4; i++) begin
      if (!ren[i] || raddr[i] == 5'd0) begin
        rdata[i] = '0;
      end else if (wb.slot1.wren && wb.slot1.waddr == raddr[i]) begin
        rdata[i] = wb.slot1.wdata; // Write-through, slot1 first.
      end else if (wb.slot0.wren && wb.slot0.waddr == raddr[i]) begin
        rdata[i] = wb.slot0.wdata;
      end else begin
        rdata[i] = regs[raddr[i]];
      end
    end
  end

  // Later assignment wins on a shared address.
  always_ff @(posedge clock) begin
    if (wb.slot0.wren) begin
      regs[wb.slot0.waddr] <= wb.slot0.wdata;
    end
    if (wb.slot1.wren) begin
      regs[wb.slot1.waddr] <= wb.slot1.wdata;
    end
  end

endmodule

//--- logic/csr_file.sv
`timescale 1ns/1ps

module csr_file import core_pkg::*; import csr_pkg::*; #(
  parameter logic [1:0] fs_init = 2'b00
) (
  input logic clock,
  input logic reset,
  input csr_read_type csr_rd,
  input csr_write_type csr_wr,
  output logic [xlen-1:0] cdata,
  output logic [1:0] fs,
  output logic [2:0] frm
);

  logic [1:0] fs_q;
  logic [1:0] fs_new;
  fcsr_type fcsr_q;
  fcsr_type fcsr_new;

  always_comb begin
    fs_new = fs_q;
    fcsr_new = fcsr_q;
    if (csr_wr.cwren) begin
      case (csr_wr.cwaddr)
        csr_fflags: fcsr_new.fields.fflags = csr_wr.cwdata[4:0];
        csr_frm: fcsr_new.fields.frm = csr_wr.cwdata[2:0];
        csr_fcsr: fcsr_new.raw = {24'd0, csr_wr.cwdata[7:0]};
        csr_mstatus: fs_new = csr_wr.cwdata[14:13];
        default: fs_new = fs_q;
      endcase
    end

    cdata = '0;
    if (csr_rd.crden) begin
      case (csr_rd.craddr)
        csr_fflags: cdata = {27'd0, fcsr_new.fields.fflags};
        csr_frm: cdata = {29'd0, fcsr_new.fields.frm};
        csr_fcsr: cdata = fcsr_new.raw;
        csr_mstatus: cdata = {17'd0, fs_new, 13'd0}; // Only fs is kept.
        default: cdata = '0;
      endcase
    end
  end

  assign fs = fs_new;
  assign frm = fcsr_new.fields.frm;

  always_ff @(posedge clock) begin
    if (!reset) begin
      fs_q <= fs_init;
      fcsr_q <= '0;
    end else begin
      fs_q <= fs_new;
      fcsr_q <= fcsr_new;
    end
  end

endmodule

//--- logic/issue_top.sv
`timescale 1ns/1ps

module issue_top import core_pkg::*; import csr_pkg::*; #(
  parameter int reg_depth = 32,
  parameter logic [1:0] fs_init = 2'b00
) (
  input logic clock,
  input logic reset,
  input decode_pair_type pair,
  input execute_state_type ex_state,
  input writeback_type wb,
  input csr_write_type csr_wr,
  input logic clear,
  input logic hold,
  output calculation_type issue0,
  output calculation_type issue1,
  output logic stall,
  output logic halt
);

  calculation_type cand0;
  calculation_type cand1;
  logic split;
  logic [3:0][4:0] raddr;
  logic [3:0] ren;
  logic [3:0][xlen-1:0] rdata;
  csr_read_type csr_rd;
  logic [xlen-1:0] cdata;
  logic [1:0] fs;
  logic [2:0] frm;

  pair_hazard i_pair_hazard (
    .clock(clock),
    .reset(reset),
    .pair(pair),
    .clear(clear),
    .hold(hold),
    .stall(stall),
    .cand0(cand0),
    .cand1(cand1),
    .split(split)
  );

  issue_stage i_issue_stage (
    .clock(clock),
    .reset(reset),
    .cand0(cand0),
    .cand1(cand1),
    .split(split),
    .clear(clear),
    .hold(hold),
    .ex_state(ex_state),
    .raddr(raddr),
    .ren(ren),
    .rdata(rdata),
    .csr_rd(csr_rd),
    .cdata(cdata),
    .fs(fs),
    .frm(frm),
    .issue0(issue0),
    .issue1(issue1),
    .stall(stall),
    .halt(halt)
  );

  int_regfile #(.depth(reg_depth)) i_int_regfile (
    .clock(clock),
    .raddr(raddr),
    .ren(ren),
    .rdata(rdata),
    .wb(wb)
  );

  csr_file #(.fs_init(fs_init)) i_csr_file (
    .clock(clock),
    .reset(reset),
    .csr_rd(csr_rd),
    .csr_wr(csr_wr),
    .cdata(cdata),
    .fs(fs),
    .frm(frm)
  );

endmodule

//--- dv/issue_tb.sv
`timescale 1ns/1ps

module issue_tb
  import core_pkg::*;
  import csr_pkg::*;
();

  localparam int period = 20;
  localparam int num_tests = 300;
  localparam logic [11:0] csr_list [4] = '{csr_fflags, csr_frm, csr_fcsr, csr_mstatus};

  typedef struct packed {
    calculation_type issue0;
    calculation_type issue1;
    logic stall;
    logic halt;
  } expect_type;

  logic clock;
  logic reset;
  decode_pair_type pair;
  execute_state_type ex_state;
  writeback_type wb;
  csr_write_type csr_wr;
  logic clear;
  logic hold;
  calculation_type issue0;
  calculation_type issue1;
  logic stall;
  logic halt;

  logic [31:0] seed;
  logic [xlen-1:0] shadow_regs [32];
  logic [1:0] shadow_fs;
  logic [2:0] shadow_frm;
  logic [4:0] shadow_fflags;
  logic ref_pending;
  calculation_type ref_deferred;
  expect_type expected;
  logic consumed;   // Decode may move to a new pair.
  logic check_en;

  issue_top #(.reg_depth(32), .fs_init(2'b00)) i_issue_top (
    .clock(clock),
    .reset(reset),
    .pair(pair),
    .ex_state(ex_state),
    .wb(wb),
    .csr_wr(csr_wr),
    .clear(clear),
    .hold(hold),
    .issue0(issue0),
    .issue1(issue1),
    .stall(stall),
    .halt(halt)
  );

  initial begin
    clock = 1'b0;
    forever begin
      #(period / 2) clock = ~clock;
    end
  end

  function automatic logic [31:0] next_random();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return seed ^ (seed >> 15); // Low LCG bits are weak.
  endfunction

  task automatic fail_run(string why);
    $display("%s", why);
    $display("Errors found");
    $fatal(1);
  endtask

  task automatic compare_calc(string name, calculation_type got, calculation_type want);
    if (got !== want) begin
      fail_run($sformatf("error %s: got %h expected %h", name, got, want));
    end
  endtask

  task automatic compare_flag(string name, logic got, logic want);
    if (got !== want) begin
      fail_run($sformatf("error %s: got %h expected %h", name, got, want));
    end
  endtask

  function automatic logic [xlen-1:0] reg_value(logic en, logic [4:0] addr);
    if (!en || addr == 5'd0) return '0;
    if (wb.slot1.wren && wb.slot1.waddr == addr) return wb.slot1.wdata;
    if (wb.slot0.wren && wb.slot0.waddr == addr) return wb.slot0.wdata;
    return shadow_regs[addr];
  endfunction

  function automatic logic [xlen-1:0] csr_value(logic [11:0] addr);
    case (addr)
      csr_fflags: return {27'd0, shadow_fflags};
      csr_frm: return {29'd0, shadow_frm};
      csr_fcsr: return {24'd0, shadow_frm, shadow_fflags};
      csr_mstatus: return {17'd0, shadow_fs, 13'd0};
      default: return '0;
    endcase
  endfunction

  function automatic logic writes_source(calculation_type c, execute_slot_type e);
    return c.valid && e.load && ((c.op.rden1 && c.raddr1 == e.waddr) ||
                                 (c.op.rden2 && c.raddr2 == e.waddr));
  endfunction

  function automatic logic must_split(decode_pair_type p);
    logic dep;
    logic mem;
    logic csr;
    dep = p.slot0.op.wren && ((p.slot1.op.rden1 && p.slot1.raddr1 == p.slot0.waddr) ||
                              (p.slot1.op.rden2 && p.slot1.raddr2 == p.slot0.waddr));
    mem = (p.slot0.op.load || p.slot0.op.store) && (p.slot1.op.load || p.slot1.op.store);
    csr = p.slot0.op.crden || p.slot0.op.cwren || p.slot1.op.crden || p.slot1.op.cwren;
    return p.slot1.valid && (dep || mem || csr);
  endfunction

  // Expected outputs for one pair of candidates.
  function automatic expect_type predict(calculation_type c0, calculation_type c1,
                                         logic split_v);
    expect_type e;
    calculation_type s [2];
    logic hazard;
    logic fp_wait;
    logic cread;
    logic [11:0] caddr_sel;
    s[0] = c0;
    s[1] = c1;
    hazard = ex_state.ex0.cwren | ex_state.ex1.cwren | ex_state.mem_cwren;
    fp_wait = ex_state.ex0.fpuf | ex_state.ex1.fpuf | ex_state.mem_fpuf;
    cread = 1'b0;
    caddr_sel = '0;
    for (int i = 0; i < 2; i++) begin
      if (shadow_fs == 2'b00) begin
        s[i].op.illegal = s[i].op.illegal | s[i].op.fpunit | s[i].op.fpuf;
        s[i].op.fpunit = 1'b0;
        s[i].op.fpuf = 1'b0;
        s[i].rm = 3'd0;
      end else if (s[i].rm == 3'd7) begin
        s[i].rm = shadow_frm;
      end
      s[i].rdata1 = reg_value(s[i].valid & s[i].op.rden1, s[i].raddr1);
      s[i].rdata2 = reg_value(s[i].valid & s[i].op.rden2, s[i].raddr2);
      hazard = hazard | writes_source(s[i], ex_state.ex0) | writes_source(s[i], ex_state.ex1);
      if (s[i].valid && s[i].op.crden) begin
        if (!cread) begin
          caddr_sel = s[i].caddr;
        end
        cread = 1'b1;
        if (s[i].caddr == csr_fflags || s[i].caddr == csr_fcsr) begin
          hazard = hazard | fp_wait;
        end
      end
    end
    for (int i = 0; i < 2; i++) begin
      s[i].cdata = cread ? csr_value(caddr_sel) : '0;
      if (hazard) begin
        s[i].valid = 1'b0;
        s[i].op = init_operation;
      end
      if (clear) begin
        s[i] = init_calculation;
      end
    end
    e.issue0 = s[0];
    e.issue1 = s[1];
    e.stall = hazard & ~clear;
    e.halt = split_v & ~clear;
    return e;
  endfunction

  // Runs the model for the inputs just driven.
  task automatic evaluate();
    calculation_type c0;
    calculation_type c1;
    logic split_pair;
    logic was_pending;
    expect_type e;
    if (csr_wr.cwren) begin
      case (csr_wr.cwaddr)
        csr_fflags: shadow_fflags = csr_wr.cwdata[4:0];
        csr_frm: shadow_frm = csr_wr.cwdata[2:0];
        csr_fcsr: {shadow_frm, shadow_fflags} = csr_wr.cwdata[7:0];
        csr_mstatus: shadow_fs = csr_wr.cwdata[14:13];
        default: ;
      endcase
    end
    split_pair = must_split(pair);
    was_pending = ref_pending;
    c0 = ref_pending ? ref_deferred : pair.slot0;
    c1 = (ref_pending || split_pair) ? init_calculation : pair.slot1;
    e = predict(c0, c1, !ref_pending && split_pair);
    expected.stall = e.stall;
    expected.halt = e.halt;
    if (!hold) begin
      expected.issue0 = e.issue0;
      expected.issue1 = e.issue1;
    end
    if (!ref_pending && split_pair && !hold && !e.stall) begin
      ref_deferred = pair.slot1;
    end
    if (!hold && !e.stall) begin
      ref_pending = !clear && !ref_pending && split_pair;
    end
    consumed = clear || (!was_pending && !hold && !e.stall);
    if (wb.slot0.wren) shadow_regs[wb.slot0.waddr] = wb.slot0.wdata;
    if (wb.slot1.wren) shadow_regs[wb.slot1.waddr] = wb.slot1.wdata;
    check_en = 1'b1;
  endtask

  task automatic start_cycle();
    @(negedge clock);
    pair = '0;
    ex_state = '0;
    wb = '0;
    csr_wr = '0;
    clear = 1'b0;
    hold = 1'b0;
  endtask

  function automatic calculation_type simple_calc(logic [4:0] src, logic [4:0] dst);
    calculation_type c;
    c = init_calculation;
    c.valid = 1'b1;
    c.op.rden1 = 1'b1;
    c.op.wren = 1'b1;
    c.raddr1 = src;
    c.waddr = dst;
    return c;
  endfunction

  function automatic calculation_type random_calc();
    calculation_type c;
    logic [31:0] r;
    r = next_random();
    c = init_calculation;
    c.valid = 1'b1;
    c.op.rden1 = r[0];
    c.op.rden2 = r[1];
    c.op.wren = r[2];
    c.op.load = (r[5:3] == 3'd0);
    c.op.store = (r[5:3] == 3'd1);
    c.op.crden = (r[8:6] == 3'd0);
    c.op.cwren = (r[8:6] == 3'd1);
    c.op.fpunit = r[9];
    c.op.fpuf = r[9] & r[10];
    c.raddr1 = {2'b00, r[13:11]}; // Few registers, so pairs collide.
    c.raddr2 = {2'b00, r[16:14]};
    c.waddr = {2'b00, r[19:17]};
    c.caddr = csr_list[r[21:20]];
    c.rm = r[24:22];
    return c;
  endfunction

  task automatic random_side_inputs();
    logic [31:0] r;
    r = next_random();
    ex_state.ex0.load = (r[2:0] == 3'd0);
    ex_state.ex0.waddr = {2'b00, r[5:3]};
    ex_state.ex1.load = (r[8:6] == 3'd0);
    ex_state.ex1.waddr = {2'b00, r[11:9]};
    ex_state.ex0.cwren = (r[15:12] == 4'd0);
    ex_state.ex1.fpuf = (r[18:16] == 3'd0);
    ex_state.mem_fpuf = (r[21:19] == 3'd0);
    wb.slot0 = '{r[22], {2'b00, r[25:23]}, next_random()};
    wb.slot1 = '{r[26], {2'b00, r[29:27]}, next_random()};
    r = next_random();
    csr_wr = '{r[3:0] == 4'd0, csr_list[r[5:4]], next_random()};
    clear = (r[10:6] == 5'd0);
    hold = (r[14:11] == 4'd0);
    ex_state.ex1.cwren = (r[18:15] == 4'd0);
  endtask

  initial begin
    forever begin
      @(negedge clock);
      #(period / 4);
      if (check_en) begin
        compare_flag("stall", stall, expected.stall);
        compare_flag("halt", halt, expected.halt);
      end
      @(posedge clock);
      #(period / 4);
      if (check_en) begin
        compare_calc("issue0", issue0, expected.issue0);
        compare_calc("issue1", issue1, expected.issue1);
      end
    end
  end

  initial begin
    #((num_tests * 4 + 100) * period);
    fail_run("timeout: the test sequence did not finish in time");
  end

  initial begin
    decode_pair_type held;
    seed = 32'hed8e3019;
    check_en = 1'b0;
    reset = 1'b0;
    pair = '0;
    ex_state = '0;
    wb = '0;
    csr_wr = '0;
    clear = 1'b0;
    hold = 1'b0;
    ref_pending = 1'b0;
    ref_deferred = init_calculation;
    expected = '0;
    consumed = 1'b1;
    shadow_fs = 2'b00;
    shadow_frm = 3'd0;
    shadow_fflags = 5'd0;
    repeat (5) @(posedge clock);
    @(negedge clock);
    reset = 1'b1;

    for (int k = 0; k < 16; k++) begin
      start_cycle();
      wb.slot0 = '{1'b1, 5'(2 * k), next_random()};
      wb.slot1 = '{1'b1, 5'(2 * k + 1), next_random()};
      evaluate();
    end

    // FP op while fs is off.
    start_cycle();
    pair.slot0 = simple_calc(5'd1, 5'd9);
    pair.slot0.op.fpunit = 1'b1;
    pair.slot0.rm = 3'd7;
    evaluate();
    start_cycle();
    csr_wr = '{1'b1, csr_mstatus, 32'h0000_2000};
    evaluate();
    start_cycle();
    csr_wr = '{1'b1, csr_frm, 32'd3};
    pair.slot0 = simple_calc(5'd1, 5'd9);
    pair.slot0.op.fpunit = 1'b1;
    pair.slot0.rm = 3'd7;
    pair.slot1 = simple_calc(5'd2, 5'd10);
    pair.slot1.op.fpuf = 1'b1;
    pair.slot1.rm = 3'd7;
    evaluate();

    // Dependent pair, then a clear drops the deferred slot.
    start_cycle();
    pair.slot0 = simple_calc(5'd1, 5'd4);
    pair.slot1 = simple_calc(5'd4, 5'd5);
    evaluate();
    start_cycle();
    clear = 1'b1;
    evaluate();

    for (int k = 0; k < 3; k++) begin
      start_cycle();
      pair.slot0 = simple_calc(5'd6, 5'd7);
      pair.slot1 = simple_calc(5'd2, 5'd3);
      ex_state.ex1.load = (k == 0);
      ex_state.ex1.waddr = 5'd6;
      hold = (k == 1);
      evaluate();
    end

    // fcsr read behind a CSR write, then behind an fflags update.
    for (int k = 0; k < 3; k++) begin
      start_cycle();
      pair.slot0 = simple_calc(5'd0, 5'd11);
      pair.slot0.op.crden = 1'b1;
      pair.slot0.caddr = csr_fcsr;
      ex_state.mem_cwren = (k == 0);
      ex_state.ex0.fpuf = (k == 1);
      evaluate();
    end

    for (int n = 0; n < num_tests - 100; n++) begin
      held = pair;
      start_cycle();
      if (consumed) begin
        pair.slot0 = random_calc();
        pair.slot1 = random_calc();
        pair.slot1.valid = (next_random() % 32'd4 != 32'd0);
      end else begin
        pair = held;
      end
      random_side_inputs();
      evaluate();
    end

    @(negedge clock);
    check_en = 1'b0;
    $display("No errors");
    $finish;
  end

endmodule

//--- verilog.f
common/core_pkg.sv
common/csr_pkg.sv
issue/pair_hazard.sv
issue/issue_stage.sv
logic/int_regfile.sv
logic/csr_file.sv
logic/issue_top.sv
dv/issue_tb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -j 0 --top-module issue_tb -f verilog.f -o issue_sim
out=$(./obj_dir/issue_sim) || true
echo "$out"
if echo "$out" | grep -qx "No errors"; then
  exit 0
fi
exit 1
